//--- taint_unit.f
+incdir+tests
hw/taint_pkg.sv
hw/cmd_fifo.sv
hw/shadow_mem.sv
hw/taint_alu.sv
hw/taint_exec.sv
hw/taint_unit.sv
tests/taint_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the taint_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f taint_unit.f --top-module taint_unit_tb \
    --Mdir build -o taint_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit $status
fi

./build/taint_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

//--- tests/taint_model.svh
`ifndef TAINT_MODEL_SVH
`define TAINT_MODEL_SVH

// reference shadow memory, advanced in command order as commands are sent
taint_pkg::word_t model_mem [taint_pkg::MEM_WORDS] = '{default: '0};

function automatic logic [15:0] and_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (a.taint & b.value) | (b.taint & a.value) | (a.taint & b.taint);
endfunction

function automatic logic [15:0] or_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (a.taint & ~b.value) | (b.taint & ~a.value) | (a.taint & b.taint);
endfunction

function automatic logic [15:0] xor_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return a.taint | b.taint;
endfunction

// compare is open only if every bit clean in both operands agrees
function automatic logic [15:0] eq_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    logic [15:0] clean;
    clean = ~(a.taint | b.taint);
    return {15'd0, (|(a.taint | b.taint)) && (((a.value ^ b.value) & clean) == 16'd0)};
endfunction

function automatic logic [15:0] shl_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (b.taint != 16'd0) ? 16'hffff : a.taint << b.value[3:0];
endfunction

function automatic logic [15:0] shr_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (b.taint != 16'd0) ? 16'hffff : a.taint >> b.value[3:0];
endfunction

function automatic logic [15:0] mul_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (a.taint != 16'd0 || b.taint != 16'd0) ? 16'hffff : 16'h0000;
endfunction

// no clean one in a, so a tainted bit decides the result
function automatic logic [15:0] redor_taint(taint_pkg::word_t a);
    return {15'd0, (a.taint != 16'd0) && ((a.value & ~a.taint) == 16'd0)};
endfunction

function automatic logic [15:0] sti_taint(taint_pkg::word_t a, taint_pkg::word_t b);
    return (a.taint[2:0] != 3'd0) ? 16'hffff : b.taint;
endfunction

// runs one command on the model and returns the result it must produce
function automatic taint_pkg::res_t execute_model(taint_pkg::cmd_t c);
    taint_pkg::word_t a;
    taint_pkg::word_t b;
    taint_pkg::res_t  r;
    a = model_mem[c.src_a];
    b = model_mem[c.src_b];
    r.addr = c.dst;
    case (c.op)
        taint_pkg::OP_AND:   r.word = '{a.value & b.value, and_taint(a, b)};
        taint_pkg::OP_OR:    r.word = '{a.value | b.value, or_taint(a, b)};
        taint_pkg::OP_EQ:    r.word = '{(a.value == b.value) ? 16'd1 : 16'd0, eq_taint(a, b)};
        taint_pkg::OP_SHL:   r.word = '{a.value << b.value[3:0], shl_taint(a, b)};
        taint_pkg::OP_SHR:   r.word = '{a.value >> b.value[3:0], shr_taint(a, b)};
        taint_pkg::OP_MUL:   r.word = '{a.value * b.value, mul_taint(a, b)};
        taint_pkg::OP_REDOR: r.word = '{{15'd0, |a.value}, redor_taint(a)};
        taint_pkg::OP_LOAD:  r.word = c.imm;
        taint_pkg::OP_STI: begin
            r.addr = a.value[2:0];
            r.word = '{b.value, sti_taint(a, b)};
        end
        default:             r.word = '{a.value ^ b.value, xor_taint(a, b)};
    endcase
    model_mem[r.addr] = r.word;
    return r;
endfunction

function automatic int count_tainted();
    int n;
    n = 0;
    for (int i = 0; i < taint_pkg::MEM_WORDS; i++) begin
        if (model_mem[i].taint != '0) begin
            n++;
        end
    end
    return n;
endfunction

`endif

//--- tests/taint_unit_tb.sv
`timescale 1ns/10ps

module taint_unit_tb;

    localparam int CMD_DEPTH   = 4;
    localparam int RES_CREDITS = 2;
    localparam int TIMEOUT     = 200;
    localparam int HOLD_CMDS   = CMD_DEPTH + RES_CREDITS + 2;

    // expected result and tainted-word count after it
    typedef struct packed {
        taint_pkg::res_t res;
        int              count;
    } expect_t;

    logic                        pos_clk;
    logic                        pos_arst;
    logic                        cmd_valid;
    taint_pkg::cmd_t             cmd;
    logic                        cmd_credit;
    logic                        res_valid;
    taint_pkg::res_t             res;
    logic                        res_credit;
    logic [taint_pkg::CNT_W-1:0] tainted_words;

    // running totals of command and result traffic
    int      sent         = 0;
    int      credits_back = 0;
    int      res_seen     = 0;
    int      res_returned = 0;
    logic    hold_res     = 1'b0;
    expect_t exp_q [$];

    taint_pkg::op_e alu_ops [8] = '{
        taint_pkg::OP_AND, taint_pkg::OP_OR, taint_pkg::OP_XOR, taint_pkg::OP_EQ,
        taint_pkg::OP_SHL, taint_pkg::OP_SHR, taint_pkg::OP_MUL, taint_pkg::OP_REDOR
    };

    `include "taint_model.svh"

    taint_unit #(
        .CMD_DEPTH   (CMD_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) dut (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_credit    (cmd_credit),
        .res_valid     (res_valid),
        .res           (res),
        .res_credit    (res_credit),
        .tainted_words (tainted_words)
    );

    initial begin
        pos_clk = 1'b0;
        forever #20 pos_clk = ~pos_clk;
    end

    task automatic check_equal(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // inputs change 2 ns after each rising edge
    task automatic next_cycle();
        @(posedge pos_clk);
        #2;
        cmd_valid = 1'b0;
        if (!hold_res && res_returned < res_seen) begin
            res_credit = 1'b1;
            res_returned++;
        end else begin
            res_credit = 1'b0;
        end
    endtask

    function automatic int free_credits();
        return CMD_DEPTH - sent + credits_back;
    endfunction

    function automatic taint_pkg::word_t random_word();
        taint_pkg::word_t w;
        w.value = 16'($urandom);
        // mix clean, sparse and dense taint
        case ($urandom % 3)
            0:       w.taint = '0;
            1:       w.taint = 16'($urandom & $urandom & $urandom);
            default: w.taint = 16'($urandom);
        endcase
        return w;
    endfunction

    function automatic taint_pkg::cmd_t make_cmd(input taint_pkg::op_e op);
        taint_pkg::cmd_t c;
        c.op    = op;
        c.dst   = 3'($urandom);
        c.src_a = 3'($urandom);
        c.src_b = 3'($urandom);
        c.imm   = random_word();
        return c;
    endfunction

    task automatic drive_cmd(input taint_pkg::cmd_t c);
        expect_t e;
        e.res   = execute_model(c);
        e.count = count_tainted();
        exp_q.push_back(e);
        cmd       = c;
        cmd_valid = 1'b1;
        sent++;
    endtask

    task automatic send_cmd(input taint_pkg::cmd_t c);
        int waited;
        waited = 0;
        while (free_credits() == 0) begin
            if (waited == TIMEOUT) begin
                stop_run("timed out waiting for a command credit");
            end
            waited++;
            next_cycle();
        end
        drive_cmd(c);
        next_cycle();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (res_seen < sent || res_returned < res_seen || credits_back < sent) begin
            if (waited == TIMEOUT) begin
                stop_run("timed out waiting for outstanding results");
            end
            waited++;
            next_cycle();
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge pos_clk) begin
        if (!pos_arst) begin
            if (cmd_credit) begin
                credits_back++;
                if (credits_back > sent) begin
                    stop_run("more command credits returned than commands sent");
                end
            end
            if (res_valid) begin
                if (res_seen >= exp_q.size()) begin
                    stop_run("result arrived with no command outstanding");
                end else begin
                    check_equal("result addr", int'(res.addr), int'(exp_q[res_seen].res.addr));
                    check_equal("result value", int'(res.word.value),
                                int'(exp_q[res_seen].res.word.value));
                    check_equal("result taint", int'(res.word.taint),
                                int'(exp_q[res_seen].res.word.taint));
                    check_equal("tainted_words", int'(tainted_words), exp_q[res_seen].count);
                    res_seen++;
                end
            end
        end
    end

    initial begin
        taint_pkg::cmd_t c;
        taint_pkg::cmd_t ld;
        int              base;
        int              n;
        void'($urandom(34));
        pos_arst   = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        res_credit = 1'b0;
        repeat (4) @(posedge pos_clk);
        #2;
        pos_arst = 1'b0;
        @(negedge pos_clk);
        check_equal("res_valid after reset", int'(res_valid), 0);
        check_equal("cmd_credit after reset", int'(cmd_credit), 0);
        check_equal("tainted_words after reset", int'(tainted_words), 0);
        next_cycle();

        // fill every word
        for (int i = 0; i < taint_pkg::MEM_WORDS; i++) begin
            c = make_cmd(taint_pkg::OP_LOAD);
            c.dst = 3'(i);
            send_cmd(c);
        end

        // random alu traffic with periodic reloads so taint does not saturate
        for (int i = 0; i < 330; i++) begin
            if (i % 11 == 10) begin
                c = make_cmd(taint_pkg::OP_LOAD);
            end else begin
                c = make_cmd(alu_ops[3'($urandom)]);
            end
            send_cmd(c);
        end

        // store indirect through address words with and without low-bit taint
        for (int i = 0; i < 40; i++) begin
            ld = make_cmd(taint_pkg::OP_LOAD);
            case (i % 3)
                0:       ld.imm.taint = '0;
                1:       ld.imm.taint = 16'h0001 << ($urandom % 3);
                default: ld.imm.taint = 16'($urandom) & 16'hfff8;
            endcase
            send_cmd(ld);
            c = make_cmd(taint_pkg::OP_STI);
            c.src_a = ld.dst;
            send_cmd(c);
        end

        // withhold result credits until the sender stalls
        drain();
        hold_res = 1'b1;
        base     = res_seen;
        n        = 0;
        for (int i = 0; i < 40; i++) begin
            if (n < HOLD_CMDS && free_credits() > 0) begin
                drive_cmd(make_cmd(alu_ops[3'($urandom)]));
                n++;
            end
            next_cycle();
        end
        check_equal("results with credits held", res_seen - base, RES_CREDITS);
        check_equal("command credits while stalled", free_credits(), 0);
        hold_res = 1'b0;
        while (n < HOLD_CMDS) begin
            send_cmd(make_cmd(alu_ops[3'($urandom)]));
            n++;
        end
        drain();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- hw/taint_unit.sv
`timescale 1ns/10ps

module taint_unit #(
    parameter int CMD_DEPTH   = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic                        pos_clk,
    input  logic                        pos_arst,
    input  logic                        cmd_valid,
    input  taint_pkg::cmd_t             cmd,
    output logic                        cmd_credit,
    output logic                        res_valid,
    output taint_pkg::res_t             res,
    input  logic                        res_credit,
    output logic [taint_pkg::CNT_W-1:0] tainted_words
);

    taint_pkg::cmd_t              fifo_cmd;
    logic                         fifo_empty;
    logic                         fifo_pop;
    logic [taint_pkg::ADDR_W-1:0] rd_addr_a;
    logic [taint_pkg::ADDR_W-1:0] rd_addr_b;
    taint_pkg::word_t             rd_a;
    taint_pkg::word_t             rd_b;
    logic                         wr_en;
    logic [taint_pkg::ADDR_W-1:0] wr_addr;
    taint_pkg::word_t             wr_word;

    cmd_fifo #(
        .DEPTH (CMD_DEPTH)
    ) u_fifo (
        .pos_clk   (pos_clk),
        .pos_arst  (pos_arst),
        .push      (cmd_valid),
        .push_data (cmd),
        .pop       (fifo_pop),
        .pop_data  (fifo_cmd),
        .empty     (fifo_empty),
        .credit    (cmd_credit)
    );

    shadow_mem u_mem (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_a          (rd_a),
        .rd_b          (rd_b),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .tainted_words (tainted_words)
    );

    taint_exec #(
        .RES_CREDITS (RES_CREDITS)
    ) u_exec (
        .pos_clk    (pos_clk),
        .pos_arst   (pos_arst),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .cmd        (fifo_cmd),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_word    (wr_word),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

endmodule

//--- hw/taint_exec.sv
`timescale 1ns/10ps

module taint_exec #(
    parameter int RES_CREDITS = 2
) (
    input  logic                         pos_clk,
    input  logic                         pos_arst,
    input  logic                         fifo_empty,
    output logic                         fifo_pop,
    input  taint_pkg::cmd_t              cmd,
    output logic [taint_pkg::ADDR_W-1:0] rd_addr_a,
    output logic [taint_pkg::ADDR_W-1:0] rd_addr_b,
    input  taint_pkg::word_t             rd_a,
    input  taint_pkg::word_t             rd_b,
    output logic                         wr_en,
    output logic [taint_pkg::ADDR_W-1:0] wr_addr,
    output taint_pkg::word_t             wr_word,
    output logic                         res_valid,
    output taint_pkg::res_t              res,
    input  logic                         res_credit
);

    localparam int CRED_W = $clog2(RES_CREDITS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_e;

    state_e            state;
    taint_pkg::cmd_t   cmd_q;
    logic [CRED_W-1:0] res_cnt;
    logic              can_start;

    // a result credit is taken up front so the result never waits
    assign can_start = !fifo_empty && (res_cnt != '0);
    assign fifo_pop  = can_start && (state != ST_READ);

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  state <= fifo_pop ? ST_READ : ST_IDLE;
                ST_READ:  state <= ST_WRITE;
                ST_WRITE: state <= fifo_pop ? ST_READ : ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // held command
    always_ff @(posedge pos_clk) begin
        if (fifo_pop) begin
            cmd_q <= cmd;
        end
    end

    assign rd_addr_a = cmd_q.src_a;
    assign rd_addr_b = cmd_q.src_b;

    taint_alu u_alu (
        .op     (cmd_q.op),
        .dst    (cmd_q.dst),
        .a      (rd_a),
        .b      (rd_b),
        .imm    (cmd_q.imm),
        .y      (wr_word),
        .y_addr (wr_addr)
    );

    // read words are valid in the write state
    assign wr_en = (state == ST_WRITE);

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= wr_en;
        end
    end

    always_ff @(posedge pos_clk) begin
        if (wr_en) begin
            res.addr <= wr_addr;
            res.word <= wr_word;
        end
    end

    // result credits
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_cnt <= CRED_W'(RES_CREDITS);
        end else begin
            case ({res_credit, fifo_pop})
                2'b10:   res_cnt <= res_cnt + 1'b1;
                2'b01:   res_cnt <= res_cnt - 1'b1;
                default: res_cnt <= res_cnt;
            endcase
        end
    end

endmodule

//--- hw/taint_alu.sv
`timescale 1ns/10ps

module taint_alu (
    input  taint_pkg::op_e               op,
    input  logic [taint_pkg::ADDR_W-1:0] dst,
    input  taint_pkg::word_t             a,
    input  taint_pkg::word_t             b,
    input  taint_pkg::word_t             imm,
    output taint_pkg::word_t             y,
    output logic [taint_pkg::ADDR_W-1:0] y_addr
);

    localparam int W = taint_pkg::DATA_W;

    logic [W-1:0] ta;
    logic [W-1:0] tb;
    logic [W-1:0] clean;
    logic [3:0]   shamt;
    logic         any_taint;

    assign ta        = a.taint;
    assign tb        = b.taint;
    // bits untainted in both operands
    assign clean     = ~(ta | tb);
    assign shamt     = b.value[3:0];
    assign any_taint = |{ta, tb};

    always_comb begin
        y = '0;
        case (op)
            taint_pkg::OP_AND: begin
                y.value = a.value & b.value;
                y.taint = (ta & b.value) | (tb & a.value) | (ta & tb);
            end
            taint_pkg::OP_OR: begin
                y.value = a.value | b.value;
                y.taint = (ta & ~b.value) | (tb & ~a.value) | (ta & tb);
            end
            taint_pkg::OP_EQ: begin
                y.value    = W'(a.value == b.value);
                // result can flip only if the clean bits already agree
                y.taint[0] = any_taint && ((a.value & clean) == (b.value & clean));
            end
            taint_pkg::OP_SHL: begin
                y.value = a.value << shamt;
                y.taint = (|tb) ? {W{1'b1}} : ta << shamt;
            end
            taint_pkg::OP_SHR: begin
                y.value = a.value >> shamt;
                y.taint = (|tb) ? {W{1'b1}} : ta >> shamt;
            end
            taint_pkg::OP_MUL: begin
                y.value = a.value * b.value;
                y.taint = {W{any_taint}};
            end
            taint_pkg::OP_REDOR: begin
                y.value    = W'(|a.value);
                // a clean one already decides the result
                y.taint[0] = (|ta) && !(|(~ta & a.value));
            end
            taint_pkg::OP_LOAD: begin
                y = imm;
            end
            taint_pkg::OP_STI: begin
                y.value = b.value;
                // tainted address spreads over the whole stored word
                y.taint = (|ta[taint_pkg::ADDR_W-1:0]) ? {W{1'b1}} : tb;
            end
            default: begin
                // xor, also the fallback rule
                y.value = a.value ^ b.value;
                y.taint = ta | tb;
            end
        endcase
    end

    // store-indirect takes its address from word a
    always_comb begin
        if (op == taint_pkg::OP_STI) begin
            y_addr = a.value[taint_pkg::ADDR_W-1:0];
        end else begin
            y_addr = dst;
        end
    end

endmodule

//--- hw/shadow_mem.sv
`timescale 1ns/10ps

module shadow_mem (
    input  logic                         pos_clk,
    input  logic                         pos_arst,
    input  logic [taint_pkg::ADDR_W-1:0] rd_addr_a,
    input  logic [taint_pkg::ADDR_W-1:0] rd_addr_b,
    output taint_pkg::word_t             rd_a,
    output taint_pkg::word_t             rd_b,
    input  logic                         wr_en,
    input  logic [taint_pkg::ADDR_W-1:0] wr_addr,
    input  taint_pkg::word_t             wr_word,
    output logic [taint_pkg::CNT_W-1:0]  tainted_words
);

    taint_pkg::word_t mem [taint_pkg::MEM_WORDS];

    logic old_tainted;
    logic new_tainted;

    // entry taint before and after the write
    assign old_tainted = |mem[wr_addr].taint;
    assign new_tainted = |wr_word.taint;

    // storage, cleared so every word starts untainted
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < taint_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // registered read ports
    always_ff @(posedge pos_clk) begin
        rd_a <= mem[rd_addr_a];
        rd_b <= mem[rd_addr_b];
    end

    // count moves only when a word crosses between clean and tainted
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            tainted_words <= '0;
        end else if (wr_en && (old_tainted != new_tainted)) begin
            if (new_tainted) begin
                tainted_words <= tainted_words + 1'b1;
            end else begin
                tainted_words <= tainted_words - 1'b1;
            end
        end
    end

endmodule

//--- hw/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic            pos_clk,
    input  logic            pos_arst,
    input  logic            push,
    input  taint_pkg::cmd_t push_data,
    input  logic            pop,
    output taint_pkg::cmd_t pop_data,
    output logic            empty,
    output logic            credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    taint_pkg::cmd_t  entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] count;

    // sender credits keep pushes below DEPTH, no full check needed
    always_ff @(posedge pos_clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per freed slot, a cycle after the pop
            credit <= pop;
        end
    end

    assign pop_data = entries[rd_ptr];
    assign empty    = (count == '0);

endmodule

//--- hw/taint_pkg.sv
package taint_pkg;

    // data path and memory geometry
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 3;
    localparam int MEM_WORDS = 8;

    // tainted-word count must reach MEM_WORDS
    localparam int CNT_W = ADDR_W + 1;

    typedef enum logic [3:0] {
        OP_AND   = 4'd0,
        OP_OR    = 4'd1,
        OP_XOR   = 4'd2,
        OP_EQ    = 4'd3,
        OP_SHL   = 4'd4,
        OP_SHR   = 4'd5,
        OP_MUL   = 4'd6,
        OP_REDOR = 4'd7,
        OP_LOAD  = 4'd8,
        OP_STI   = 4'd9
    } op_e;

    // value with its shadow taint mask
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] taint;
    } word_t;

    // one command, 45 bits
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] dst;
        logic [ADDR_W-1:0] src_a;
        logic [ADDR_W-1:0] src_b;
        word_t             imm;
    } cmd_t;

    // one result, 35 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        word_t             word;
    } res_t;

endpackage
